//--- source/sd_dma_pkg.sv
/*
 * SD host DMA shared types
 * word, byte address and length types, transfer FSM states
 */

package sd_dma_pkg;

   ////////////////////////////////////////////////////////////////////
   // bus widths
   ////////////////////////////////////////////////////////////////////

   typedef logic [31:0] data_t;  // one card / RAM word
   typedef logic [63:0] addr_t;  // byte address into system memory
   typedef logic [15:0] len_t;   // transfer length in bytes

   // address step per moved word
   localparam int unsigned BYTES_PER_WORD = 4;

   ////////////////////////////////////////////////////////////////////
   // transfer engine states
   ////////////////////////////////////////////////////////////////////

   typedef enum logic [1:0] {
      IDLE,     // tfc high, waiting for start
      TO_RAM,   // rx FIFO drained into RAM
      TO_FIFO   // RAM read into tx FIFO
   } xfer_state_t;

endpackage

//--- source/sd_dma_if.sv
/*
 * SD host DMA bus bundles
 * ram_bus_if links the transfer engine to system RAM,
 * fifo_bus_if links a data FIFO to its producer and consumer
 */

`timescale 1ns/1ns

////////////////////////////////////////////////////////////////////////
// system RAM bus
////////////////////////////////////////////////////////////////////////

interface ram_bus_if
   import sd_dma_pkg::*;
();

   logic  rd;     // read strobe, rdata valid same cycle
   logic  wr;     // write strobe, taken at the rising edge
   addr_t addr;   // byte address
   data_t wdata;
   data_t rdata;

   modport master (
      output rd, wr, addr, wdata,
      input  rdata
   );

   modport slave (
      input  rd, wr, addr, wdata,
      output rdata
   );

endinterface

////////////////////////////////////////////////////////////////////////
// data FIFO bus
////////////////////////////////////////////////////////////////////////

interface fifo_bus_if
   import sd_dma_pkg::*;
();

   logic  push;
   logic  pop;
   data_t wdata;
   data_t rdata;   // head entry, fall-through
   logic  full;
   logic  empty;

   modport producer (output push, wdata, input full);
   modport consumer (output pop, input rdata, empty);
   modport fifo (
      input  push, pop, wdata,
      output rdata, full, empty
   );

endinterface

//--- source/sd_data_fifo.sv
/*
 * SD data FIFO
 * synchronous first-word-fall-through FIFO, used for the card
 * receive path and the card transmit path
 */

`timescale 1ns/1ns

module sd_data_fifo
   import sd_dma_pkg::*;
#(
   parameter int unsigned FIFO_DEPTH = 8
) (
   input logic       CLK,
   input logic       arst_n,
   fifo_bus_if.fifo  bus
);

   localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);
   localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);
   localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(FIFO_DEPTH);

   data_t            mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;   // occupancy
   logic             do_push;
   logic             do_pop;

   ////////////////////////////////////////////////////////////////////
   // flags and accepted strobes
   ////////////////////////////////////////////////////////////////////

   assign bus.full  = (count == FULL_CNT);
   assign bus.empty = (count == '0);

   assign do_push = bus.push && !bus.full;   // overflow dropped
   assign do_pop  = bus.pop && !bus.empty;   // underflow dropped

   assign bus.rdata = mem[rd_ptr];   // head shown combinationally

   ////////////////////////////////////////////////////////////////////
   // pointers and count
   ////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // idle, or push and pop together
         endcase
      end
   end

   // storage
   always_ff @(posedge CLK) begin
      if (do_push) begin
         mem[wr_ptr] <= bus.wdata;
      end
   end

endmodule

//--- source/sd_system_ram.sv
/*
 * System RAM model
 * word array behind a byte address, combinational read,
 * write on the rising clock edge
 */

`timescale 1ns/1ns

module sd_system_ram
   import sd_dma_pkg::*;
#(
   parameter int unsigned RAM_WORDS_W = 8
) (
   input logic     CLK,
   ram_bus_if.slave ram
);

   localparam int unsigned RAM_WORDS = 2 ** RAM_WORDS_W;
   localparam int unsigned OFS_W     = $clog2(BYTES_PER_WORD);

   data_t                  mem [RAM_WORDS];
   logic [RAM_WORDS_W-1:0] word_idx;

   // byte offset dropped, upper bits wrap modulo the RAM size
   assign word_idx = ram.addr[OFS_W +: RAM_WORDS_W];

   assign ram.rdata = ram.rd ? mem[word_idx] : '0;

   always_ff @(posedge CLK) begin
      if (ram.wr) begin
         mem[word_idx] <= ram.wdata;
      end
   end

endmodule

//--- source/sd_dma_transfer.sv
/*
 * SD DMA transfer engine
 * moves words between system RAM and the card data FIFOs,
 * one word per cycle while the FIFO side allows it
 */

`timescale 1ns/1ns

module sd_dma_transfer
   import sd_dma_pkg::*;
(
   input  logic            CLK,
   input  logic            arst_n,
   input  logic            start,
   input  logic            direction,     // 0 card to RAM, 1 RAM to card
   input  addr_t           address_init,
   input  len_t            length,
   output logic            tfc,
   ram_bus_if.master       ram,
   fifo_bus_if.consumer    rx,
   fifo_bus_if.producer    tx
);

   xfer_state_t state;
   xfer_state_t next_state;
   addr_t       cur_addr;     // address of the next word
   addr_t       end_addr;     // first address past the transfer
   addr_t       next_addr;
   logic        at_end;
   logic        move_to_ram;
   logic        move_to_fifo;
   logic        move;

   ////////////////////////////////////////////////////////////////////
   // word movement strobes
   ////////////////////////////////////////////////////////////////////

   assign at_end = (cur_addr == end_addr);   // only true here for length 0

   // stall while the source is empty or the sink is full
   assign move_to_ram  = (state == TO_RAM) && !rx.empty && !at_end;
   assign move_to_fifo = (state == TO_FIFO) && !tx.full && !at_end;
   assign move         = move_to_ram || move_to_fifo;

   assign rx.pop    = move_to_ram;
   assign ram.wr    = move_to_ram;
   assign ram.wdata = rx.rdata;

   assign ram.rd   = move_to_fifo;
   assign tx.push  = move_to_fifo;
   assign tx.wdata = ram.rdata;   // async RAM read feeds the push directly

   assign ram.addr = cur_addr;

   assign next_addr = move ? cur_addr + addr_t'(BYTES_PER_WORD) : cur_addr;

   assign tfc = (state == IDLE);

   ////////////////////////////////////////////////////////////////////
   // next state
   ////////////////////////////////////////////////////////////////////

   always_comb begin
      next_state = state;
      case (state)
         IDLE: begin
            if (start) begin
               next_state = direction ? TO_FIFO : TO_RAM;
            end
         end
         TO_RAM,
         TO_FIFO: begin
            // leave together with the last word, or at once for length 0
            if (next_addr == end_addr) begin
               next_state = IDLE;
            end
         end
         default: next_state = IDLE;
      endcase
   end

   ////////////////////////////////////////////////////////////////////
   // state and address counter
   ////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         state    <= IDLE;
         cur_addr <= '0;
         end_addr <= '0;
      end else begin
         state <= next_state;
         if (state == IDLE) begin
            if (start) begin   // start while busy never reaches here
               cur_addr <= address_init;
               end_addr <= address_init + addr_t'(length);
            end
         end else begin
            cur_addr <= next_addr;
         end
      end
   end

endmodule

//--- source/sd_dma_top.sv
/*
 * SD host DMA top level
 * transfer engine, receive and transmit data FIFOs and system RAM
 */

`timescale 1ns/1ns

module sd_dma_top
   import sd_dma_pkg::*;
#(
   parameter int unsigned RAM_WORDS_W = 8,
   parameter int unsigned FIFO_DEPTH  = 8
) (
   input  logic  CLK,
   input  logic  arst_n,
   input  logic  start,
   input  logic  direction,
   input  addr_t address_init,
   input  len_t  length,
   output logic  tfc,
   // card receive side
   input  logic  rx_push,
   input  data_t rx_data,
   output logic  rx_full,
   // card transmit side
   input  logic  tx_pop,
   output data_t tx_data,
   output logic  tx_empty
);

   ram_bus_if  ram_bus ();
   fifo_bus_if rx_bus ();
   fifo_bus_if tx_bus ();

   ////////////////////////////////////////////////////////////////////
   // card side of the FIFOs
   ////////////////////////////////////////////////////////////////////

   assign rx_bus.push  = rx_push;
   assign rx_bus.wdata = rx_data;
   assign rx_full      = rx_bus.full;

   assign tx_bus.pop = tx_pop;
   assign tx_data    = tx_bus.rdata;
   assign tx_empty   = tx_bus.empty;

   ////////////////////////////////////////////////////////////////////
   // blocks
   ////////////////////////////////////////////////////////////////////

   sd_dma_transfer u_transfer (
      .CLK          (CLK),
      .arst_n       (arst_n),
      .start        (start),
      .direction    (direction),
      .address_init (address_init),
      .length       (length),
      .tfc          (tfc),
      .ram          (ram_bus.master),
      .rx           (rx_bus.consumer),
      .tx           (tx_bus.producer)
   );

   sd_data_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_rx_fifo (
      .CLK    (CLK),
      .arst_n (arst_n),
      .bus    (rx_bus.fifo)
   );

   sd_data_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_tx_fifo (
      .CLK    (CLK),
      .arst_n (arst_n),
      .bus    (tx_bus.fifo)
   );

   sd_system_ram #(.RAM_WORDS_W(RAM_WORDS_W)) u_ram (
      .CLK (CLK),
      .ram (ram_bus.slave)
   );

endmodule

//--- tb/sd_dma_assert.sv
/*
 * DMA transfer engine checks
 * strobe rules of the engine against the FIFO flags and tfc,
 * bound into every sd_dma_transfer instance
 */

`timescale 1ns/1ns

module sd_dma_assert (
   input logic CLK,
   input logic arst_n,
   input logic tfc,
   input logic rx_pop,
   input logic rx_empty,
   input logic tx_push,
   input logic tx_full,
   input logic ram_rd,
   input logic ram_wr
);

   ////////////////////////////////////////////////////////////////////
   // FIFO flag rules
   ////////////////////////////////////////////////////////////////////

   a_no_rx_underflow : assert property (
      @(posedge CLK) disable iff (!arst_n) rx_pop |-> !rx_empty
   ) else $error("rx FIFO popped while empty");

   a_no_tx_overflow : assert property (
      @(posedge CLK) disable iff (!arst_n) tx_push |-> !tx_full
   ) else $error("tx FIFO pushed while full");

   ////////////////////////////////////////////////////////////////////
   // engine strobes
   ////////////////////////////////////////////////////////////////////

   // idle engine keeps all buses quiet
   a_quiet_when_idle : assert property (
      @(posedge CLK) disable iff (!arst_n) tfc |-> !(rx_pop || tx_push || ram_rd || ram_wr)
   ) else $error("strobe active while tfc is high");

   a_write_with_pop : assert property (
      @(posedge CLK) disable iff (!arst_n) ram_wr |-> rx_pop
   ) else $error("RAM write without rx FIFO pop");

endmodule

bind sd_dma_transfer sd_dma_assert u_dma_assert (
   .CLK      (CLK),
   .arst_n   (arst_n),
   .tfc      (tfc),
   .rx_pop   (rx.pop),
   .rx_empty (rx.empty),
   .tx_push  (tx.push),
   .tx_full  (tx.full),
   .ram_rd   (ram.rd),
   .ram_wr   (ram.wr)
);

//--- tb/sd_dma_tb.sv
/*
 * SD host DMA testbench
 * card-side producer and consumer, mirror memory model,
 * tx word comparison and watchdog
 */

`timescale 1ns/1ns

module sd_dma_tb
   import sd_dma_pkg::*;
();

   localparam int unsigned RAM_WORDS_W = 8;
   localparam int unsigned FIFO_DEPTH  = 8;
   localparam int unsigned RAM_WORDS   = 2 ** RAM_WORDS_W;
   localparam int unsigned SEED        = 69964;
   localparam int          CLK_PERIOD  = 4;

   // words per test and the watchdog budget
   localparam int W_BASIC     = 16;
   localparam int W_PRESSURE  = 20;
   localparam int W_BUSY      = 12;
   localparam int W_WRAP      = 8;
   localparam int TOTAL_WORDS = 2 * W_BASIC + 2 * W_PRESSURE + W_BUSY + 4 * W_WRAP;
   localparam int STALL_CYC   = 16;    // worst case cycles per word
   localparam int FIXED_CYC   = 400;   // reset, pauses, drains
   localparam int TIMEOUT_NS  = (TOTAL_WORDS * STALL_CYC + FIXED_CYC) * CLK_PERIOD;

   localparam addr_t BASIC_BASE = 64'h0000_0000_0000_0100;
   localparam addr_t PRESS_BASE = 64'h0000_0000_0000_0200;
   localparam addr_t WRAP_A     = 64'h0000_0000_0000_0300;
   localparam addr_t WRAP_B     = 64'h0000_0001_0000_0300;   // aliases WRAP_A
   localparam addr_t WRAP_C     = 64'h0000_0000_0000_0700;   // aliases WRAP_A

   logic  CLK;
   logic  arst_n;
   logic  start;
   logic  direction;
   addr_t address_init;
   len_t  length;
   logic  tfc;
   logic  rx_push;
   data_t rx_data;
   logic  rx_full;
   logic  tx_pop;
   data_t tx_data;
   logic  tx_empty;

   data_t rx_q [$];            // words still to be pushed by the card
   data_t exp_q [$];           // expected tx words, in order
   data_t mirror [RAM_WORDS];  // reference copy of system RAM
   logic  rand_idle;
   logic  cons_pause;
   logic  pop_valid;
   data_t pop_word;
   int    errors = 0;

   sd_dma_top #(
      .RAM_WORDS_W (RAM_WORDS_W),
      .FIFO_DEPTH  (FIFO_DEPTH)
   ) i_sd_dma_top (
      .CLK          (CLK),
      .arst_n       (arst_n),
      .start        (start),
      .direction    (direction),
      .address_init (address_init),
      .length       (length),
      .tfc          (tfc),
      .rx_push      (rx_push),
      .rx_data      (rx_data),
      .rx_full      (rx_full),
      .tx_pop       (tx_pop),
      .tx_data      (tx_data),
      .tx_empty     (tx_empty)
   );

   initial begin
      CLK = 1'b0;
      forever #(CLK_PERIOD / 2) CLK = ~CLK;
   end

   ////////////////////////////////////////////////////////////////////
   // reference model and checks
   ////////////////////////////////////////////////////////////////////

   // word index is address / 4, modulo the RAM size
   function automatic data_t ref_access(input bit wr, input addr_t addr, input data_t wdata);
      logic [RAM_WORDS_W-1:0] idx;
      idx = RAM_WORDS_W'((addr / addr_t'(BYTES_PER_WORD)) % addr_t'(RAM_WORDS));
      if (wr) begin
         mirror[idx] = wdata;
      end
      return mirror[idx];
   endfunction

   task automatic abort_run();
      $display("Test failures found");
      $fatal(1, "simulation stopped at the first failure");
   endtask

   task automatic check_value(input string what, input data_t got, input data_t exp);
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t ns: %s got %h expected %h", $time, what, got, exp);
         abort_run();
      end
   endtask

   ////////////////////////////////////////////////////////////////////
   // card side
   ////////////////////////////////////////////////////////////////////

   initial begin : card_producer
      rx_push = 1'b0;
      rx_data = '0;
      forever begin
         @(posedge CLK);
         if (rx_push && !rx_full) begin   // FIFO took the word at this edge
            void'(rx_q.pop_front());
         end
         if (rx_q.size() != 0 && !(rand_idle && $urandom_range(3) == 0)) begin
            rx_push <= 1'b1;
            rx_data <= rx_q[0];
         end else begin
            rx_push <= 1'b0;
         end
      end
   end

   initial begin : card_consumer
      tx_pop    = 1'b0;
      pop_valid = 1'b0;
      pop_word  = '0;
      forever begin
         @(posedge CLK);
         if (tx_pop && !tx_empty) begin
            pop_valid <= 1'b1;
            pop_word  <= tx_data;   // head word before the pop
         end else begin
            pop_valid <= 1'b0;
         end
         tx_pop <= !cons_pause && !(rand_idle && $urandom_range(3) == 0);
      end
   end

   always @(posedge CLK) begin : compare_tx
      if (pop_valid) begin
         if (exp_q.size() == 0) begin
            errors++;
            $display("[ERROR] %0t ns: tx word %h arrived with none expected", $time, pop_word);
            abort_run();
         end else begin
            check_value("tx word", pop_word, exp_q.pop_front());
         end
      end
   end

   initial begin : watchdog
      #(TIMEOUT_NS);
      $display("Timeout: the run did not finish within %0d ns, the DUT seems to hang",
               TIMEOUT_NS);
      abort_run();
   end

   ////////////////////////////////////////////////////////////////////
   // transfer helpers
   ////////////////////////////////////////////////////////////////////

   task automatic start_transfer(input logic dir, input addr_t addr, input len_t nbytes);
      @(posedge CLK);
      start        <= 1'b1;
      direction    <= dir;
      address_init <= addr;
      length       <= nbytes;
      @(posedge CLK);
      start <= 1'b0;
   endtask

   task automatic wait_done();
      do begin
         @(posedge CLK);
      end while (!tfc);
   endtask

   task automatic drain_tx();
      while (exp_q.size() != 0) begin
         @(posedge CLK);
      end
      repeat (4) @(posedge CLK);
      check_value("tx_empty after drain", data_t'(tx_empty), 32'd1);
   endtask

   task automatic run_write(input addr_t base, input int nwords, input bit prefill);
      data_t word;
      for (int i = 0; i < nwords; i++) begin
         word = $urandom;
         rx_q.push_back(word);
         void'(ref_access(1'b1, base + addr_t'(i * BYTES_PER_WORD), word));
      end
      if (prefill) begin   // let the card fill the rx FIFO first
         repeat (2 * FIFO_DEPTH) @(posedge CLK);
         check_value("rx_full before start", data_t'(rx_full), 32'd1);
      end
      start_transfer(1'b0, base, len_t'(nwords * BYTES_PER_WORD));
      wait_done();
      check_value("rx words left", data_t'(rx_q.size()), 32'd0);
   endtask

   task automatic queue_read(input addr_t base, input int nwords);
      for (int i = 0; i < nwords; i++) begin
         exp_q.push_back(ref_access(1'b0, base + addr_t'(i * BYTES_PER_WORD), '0));
      end
   endtask

   task automatic run_read(input addr_t base, input int nwords);
      queue_read(base, nwords);
      start_transfer(1'b1, base, len_t'(nwords * BYTES_PER_WORD));
      wait_done();
      drain_tx();
   endtask

   ////////////////////////////////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////////////////////////////////

   initial begin : main_seq
      void'($urandom(SEED));
      start        = 1'b0;
      direction    = 1'b0;
      address_init = '0;
      length       = '0;
      rand_idle    = 1'b0;
      cons_pause   = 1'b0;
      arst_n       = 1'b0;
      repeat (2) @(posedge CLK);
      arst_n <= 1'b1;
      @(posedge CLK);

      // reset values
      check_value("tfc after reset", data_t'(tfc), 32'd1);
      check_value("tx_empty after reset", data_t'(tx_empty), 32'd1);
      check_value("rx_full after reset", data_t'(rx_full), 32'd0);

      // plain write and read back
      run_write(BASIC_BASE, W_BASIC, 1'b1);
      run_read(BASIC_BASE, W_BASIC);

      // random idling, read longer than the FIFO with the card paused
      rand_idle <= 1'b1;
      run_write(PRESS_BASE, W_PRESSURE, 1'b0);
      cons_pause <= 1'b1;
      queue_read(PRESS_BASE, W_PRESSURE);
      start_transfer(1'b1, PRESS_BASE, len_t'(W_PRESSURE * BYTES_PER_WORD));
      repeat (3 * FIFO_DEPTH) @(posedge CLK);
      check_value("tfc while tx stalled", data_t'(tfc), 32'd0);
      check_value("tx_empty while tx stalled", data_t'(tx_empty), 32'd0);
      cons_pause <= 1'b0;
      wait_done();
      drain_tx();

      // zero length in both directions
      start_transfer(1'b1, BASIC_BASE, '0);
      wait_done();
      repeat (4) @(posedge CLK);
      check_value("tx_empty after zero read", data_t'(tx_empty), 32'd1);
      start_transfer(1'b0, BASIC_BASE, '0);
      wait_done();

      // second start during a stalled read, exactly the first read's words come back
      cons_pause <= 1'b1;
      queue_read(PRESS_BASE, W_BUSY);
      start_transfer(1'b1, PRESS_BASE, len_t'(W_BUSY * BYTES_PER_WORD));
      repeat (2 * FIFO_DEPTH) @(posedge CLK);
      start_transfer(1'b0, PRESS_BASE + 64'd8, len_t'(8 * BYTES_PER_WORD));
      check_value("tfc after start while busy", data_t'(tfc), 32'd0);
      cons_pause <= 1'b0;
      wait_done();
      drain_tx();

      // aliasing regions, later write wins
      run_write(WRAP_A, W_WRAP, 1'b0);
      run_write(WRAP_B, W_WRAP, 1'b0);
      run_read(WRAP_A, W_WRAP);
      run_read(WRAP_C, W_WRAP);

      repeat (4) @(posedge CLK);
      if (errors == 0) begin
         $display("All tests passed!");
         $finish;
      end else begin
         $display("%0d check(s) failed", errors);
         abort_run();
      end
   end

endmodule

//--- verilog.f
source/sd_dma_pkg.sv
source/sd_dma_if.sv
source/sd_data_fifo.sv
source/sd_system_ram.sv
source/sd_dma_transfer.sv
source/sd_dma_top.sv
tb/sd_dma_assert.sv
tb/sd_dma_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the SD DMA testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module sd_dma_tb -f verilog.f -o sd_dma_sim \
   || { echo "build failed"; exit 1; }

./obj_dir/sd_dma_sim > sim.log 2>&1
cat sim.log

grep -qF 'All tests passed!' sim.log && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
